// ==== program.hex ====
// one 32-bit instruction word per line, hex, starting at address 0x00
// the comment after each word gives its byte address and assembly
00500093 // 00: addi x1, x0, 5
00308113 // 04: addi x2, x1, 3
002081B3 // 08: add  x3, x1, x2
00218233 // 0c: add  x4, x3, x2
00402823 // 10: sw   x4, 16(x0)
01002283 // 14: lw   x5, 16(x0)
00128333 // 18: add  x6, x5, x1
00131663 // 1c: bne  x6, x1, +12
00100393 // 20: addi x7, x0, 1
00200413 // 24: addi x8, x0, 2
00208463 // 28: beq  x1, x2, +8
00900493 // 2c: addi x9, x0, 9
0140056F // 30: jal  x10, +20
00150613 // 34: addi x12, x10, 1
07B00013 // 38: addi x0, x0, 123
006006B3 // 3c: add  x13, x0, x6
0000006F // 40: jal  x0, 0
04D00593 // 44: addi x11, x0, 77
00050067 // 48: jalr x0, 0(x10)
00000013 // 4c: nop
00000013 // 50: nop

// ==== sources.f ====
logic/rv_isa_pkg.sv
logic/pipe_ctrl_pkg.sv
logic/hazard_unit.sv
logic/register_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/data_memory.sv
logic/riscv_pipeline.sv
testbench/tb_clock_gen.sv
testbench/riscv_pipeline_assertions.sv
testbench/tb_riscv_pipeline.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module tb_riscv_pipeline -f sources.f -o tb_sim
	-./obj_dir/tb_sim > sim.log 2>&1
	cat sim.log
	! grep -q "TEST RESULT: FAIL" sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== testbench/tb_riscv_pipeline.sv ====
`timescale 1ns/1ns

module tb_riscv_pipeline import rv_isa_pkg::*; ();

    // cycles allowed between two retirements, covers stalls and redirects
    localparam int retire_timeout = 40;
    localparam int reset_timeout = 20;
    // first writeback lands four cycles after release
    localparam int quiet_cycles = 4;
    // the closing self loop writes only x0
    localparam int drain_cycles = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  retire_valid;
    logic [reg_addr_w-1:0] retire_rd;
    logic [xlen-1:0]       retire_data;

    // architectural register model of program.hex, run in program order
    logic [xlen-1:0]       arch [32];
    logic [xlen-1:0]       stored_word;
    // expected retire stream
    string                 exp_test [$];
    logic [reg_addr_w-1:0] exp_rd [$];
    logic [xlen-1:0]       exp_data [$];

    tb_clock_gen u_clock (
        .clk(clk),
        .rst_n(rst_n)
    );

    riscv_pipeline DUT (
        .clk(clk),
        .rst_n(rst_n),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    task automatic end_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // queue the current model value of rd as the next retirement
    task automatic add_expected(string test, logic [reg_addr_w-1:0] rd);
        exp_test.push_back(test);
        exp_rd.push_back(rd);
        exp_data.push_back(arch[rd]);
    endtask

    task automatic build_expected();
        foreach (arch[i]) begin
            arch[i] = '0;
        end
        // dependent chain, each one uses the last or the one before
        arch[1] = arch[0] + 32'd5;
        add_expected("forward chain", 5'd1);
        arch[2] = arch[1] + 32'd3;
        add_expected("forward from memory", 5'd2);
        arch[3] = arch[1] + arch[2];
        add_expected("forward from memory and writeback", 5'd3);
        arch[4] = arch[3] + arch[2];
        add_expected("forward from writeback", 5'd4);
        // sw x4 and lw x5 hit the same word
        stored_word = arch[4];
        arch[5] = stored_word;
        add_expected("load after store", 5'd5);
        arch[6] = arch[5] + arch[1];
        add_expected("load-use stall", 5'd6);
        // bne x6, x1 jumps over the two addi when taken
        if (arch[6] == arch[1]) begin
            arch[7] = 32'd1;
            add_expected("bne not taken", 5'd7);
            arch[8] = 32'd2;
            add_expected("bne not taken", 5'd8);
        end
        // beq x1, x2 falls through to addi x9 when not taken
        if (arch[1] != arch[2]) begin
            arch[9] = 32'd9;
            add_expected("beq not taken", 5'd9);
        end
        // jal at 0x30 links 0x34 and lands on the subroutine at 0x44
        arch[10] = 32'h30 + 32'd4;
        add_expected("jal link", 5'd10);
        arch[11] = 32'd77;
        add_expected("jal target", 5'd11);
        // jalr x10 comes back to 0x34
        arch[12] = arch[10] + 32'd1;
        add_expected("jalr return", 5'd12);
        // addi x0 is dropped, x0 still reads as zero
        arch[13] = arch[0] + arch[6];
        add_expected("x0 read", 5'd13);
    endtask

    // a failing bound assertion ends the run at once
    always @(negedge clk) begin
        if (DUT.u_assertions.error_count != 0) begin
            $display("a bound assertion on the DUT failed");
            end_with_failure();
        end
    end

    initial begin
        int cycles;
        int idx;
        build_expected();

        // outputs are sampled on the falling edge, away from the drive edge
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            assert (!retire_valid) else begin
                $display("retire_valid went high while reset was held");
                end_with_failure();
            end
        end while (!rst_n && cycles < reset_timeout);
        if (!rst_n) begin
            $display("reset was never released");
            end_with_failure();
        end

        // the release cycle was checked above
        repeat (quiet_cycles - 1) begin
            @(negedge clk);
            assert (!retire_valid) else begin
                $display("FAILED reset quiet: expected no retirement, actual rd x%0d",
                         retire_rd);
                end_with_failure();
            end
        end

        for (idx = 0; idx < exp_rd.size(); idx++) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
            end while (!retire_valid && cycles < retire_timeout);
            if (!retire_valid) begin
                $display("the core stopped retiring after %0d of %0d writes",
                         idx, exp_rd.size());
                end_with_failure();
            end
            assert (retire_rd == exp_rd[idx]) else begin
                $display("FAILED %s: expected rd x%0d, actual rd x%0d",
                         exp_test[idx], exp_rd[idx], retire_rd);
                end_with_failure();
            end
            assert (retire_data == exp_data[idx]) else begin
                $display("FAILED %s: expected x%0d = 0x%08h, actual 0x%08h",
                         exp_test[idx], exp_rd[idx], exp_data[idx], retire_data);
                end_with_failure();
            end
        end

        // skipped or flushed writes must not show up late
        repeat (drain_cycles) begin
            @(negedge clk);
            assert (!retire_valid) else begin
                $display("FAILED drain: expected no retirement, actual x%0d = 0x%08h",
                         retire_rd, retire_data);
                end_with_failure();
            end
        end

        if (DUT.u_assertions.error_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("%0d bound assertions failed on the DUT",
                     DUT.u_assertions.error_count);
            end_with_failure();
        end
    end

endmodule

// ==== testbench/riscv_pipeline_assertions.sv ====
`timescale 1ns/1ns

module riscv_pipeline_assertions import rv_isa_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  retire_valid,
    input logic [reg_addr_w-1:0] retire_rd,
    input logic [xlen-1:0]       retire_data,
    input logic                  pc_src,
    input logic                  flush
);

    // read by the testbench top
    int error_count = 0;

    // nothing leaves writeback while reset is held
    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !retire_valid)
        else begin
            $error("retire_valid high during reset");
            error_count++;
        end

    // x0 writes are never retirements
    rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (retire_rd != '0))
        else begin
            $error("retirement reported for x0");
            error_count++;
        end

    retire_ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({retire_valid, retire_rd}))
        else begin
            $error("retire_valid or retire_rd unknown");
            error_count++;
        end

    // m/w data has no reset, so only a real retirement must be known
    retire_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> !$isunknown(retire_data))
        else begin
            $error("retire_data unknown on a retirement");
            error_count++;
        end

    // a redirect always flushes the two younger stages
    flush_with_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        flush == pc_src)
        else begin
            $error("flush and pc_src differ");
            error_count++;
        end

endmodule

bind riscv_pipeline riscv_pipeline_assertions u_assertions (
    .clk(clk),
    .rst_n(rst_n),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd),
    .retire_data(retire_data),
    .pc_src(pc_src),
    .flush(flush)
);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 40 ns period
    localparam int half_period = 20;
    localparam int reset_cycles = 4;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== logic/riscv_pipeline.sv ====
`timescale 1ns/1ns

module riscv_pipeline import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic                  retire_valid,
    output logic [reg_addr_w-1:0] retire_rd,
    output logic [xlen-1:0]       retire_data
);

    // fetch
    logic [xlen-1:0] pc;
    logic [xlen-1:0] imem [imem_words];
    logic [xlen-1:0] f_instr;
    // f/d
    logic [xlen-1:0] f_d_pc;
    logic [xlen-1:0] f_d_instr;
    // decode outputs
    opcode_t               d_opcode;
    logic [reg_addr_w-1:0] d_rs1, d_rs2, d_rd;
    logic [xlen-1:0]       d_imm, d_val_a, d_val_b;
    alu_op_t               d_alu_op;
    logic d_reg_write, d_mem_read, d_mem_write, d_branch, d_branch_ne;
    logic d_jump, d_jalr, d_src_b_imm, d_src_a_pc;
    // d/e
    logic [xlen-1:0]       d_e_pc, d_e_val_a, d_e_val_b, d_e_imm;
    opcode_t               d_e_opcode;
    logic [reg_addr_w-1:0] d_e_rs1, d_e_rs2, d_e_rd;
    alu_op_t               d_e_alu_op;
    logic d_e_reg_write, d_e_mem_read, d_e_mem_write, d_e_branch, d_e_branch_ne;
    logic d_e_jump, d_e_jalr, d_e_src_b_imm, d_e_src_a_pc;
    // execute outputs
    logic [xlen-1:0] ex_alu_result, ex_store_data, ex_target;
    logic            ex_branch_taken;
    // e/m
    opcode_t               e_m_opcode;
    logic [reg_addr_w-1:0] e_m_rd;
    logic e_m_reg_write, e_m_mem_read, e_m_mem_write;
    logic [xlen-1:0]       e_m_alu_result, e_m_store_data;
    // memory stage
    logic [xlen-1:0] dmem_rd_data, m_result;
    // m/w
    opcode_t               m_w_opcode;
    logic [reg_addr_w-1:0] m_w_rd;
    logic                  m_w_reg_write;
    logic [xlen-1:0]       m_w_result;
    // hazard controls
    forward_type fwd_a, fwd_b;
    logic pc_en, f_d_en, d_e_en, no_op, pc_src, flush;

    initial begin
        $readmemh("program.hex", imem);
    end

    assign f_instr = imem[pc[$clog2(imem_words)+1:2]];

    // redirect beats the stall hold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_src) begin
            pc <= ex_target;
        end else if (pc_en) begin
            pc <= pc + 32'd4;
        end
    end

    // an all-zero word decodes as a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || flush) begin
            f_d_instr <= '0;
        end else if (f_d_en) begin
            f_d_instr <= f_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (f_d_en) begin
            f_d_pc <= pc;
        end
    end

    decode_unit u_decode (
        .instr(f_d_instr), .opcode(d_opcode), .rs1(d_rs1), .rs2(d_rs2), .rd(d_rd),
        .imm(d_imm), .alu_op(d_alu_op), .reg_write(d_reg_write), .mem_read(d_mem_read),
        .mem_write(d_mem_write), .branch(d_branch), .branch_ne(d_branch_ne),
        .jump(d_jump), .jalr(d_jalr), .src_b_imm(d_src_b_imm), .src_a_pc(d_src_a_pc)
    );

    register_file u_regs (
        .clk(clk), .rst_n(rst_n), .rd_addr_a(d_rs1), .rd_addr_b(d_rs2),
        .rd_data_a(d_val_a), .rd_data_b(d_val_b),
        .wr_en(m_w_reg_write), .wr_addr(m_w_rd), .wr_data(m_w_result)
    );

    // d/e control, a flush or a load-use stall loads a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n || flush || no_op) begin
            d_e_opcode    <= op_nop;
            d_e_rs1       <= '0;
            d_e_rs2       <= '0;
            d_e_rd        <= '0;
            {d_e_reg_write, d_e_mem_read, d_e_mem_write, d_e_branch, d_e_branch_ne} <= '0;
            {d_e_jump, d_e_jalr, d_e_src_b_imm, d_e_src_a_pc} <= '0;
        end else if (d_e_en) begin
            d_e_opcode    <= d_opcode;
            d_e_rs1       <= d_rs1;
            d_e_rs2       <= d_rs2;
            d_e_rd        <= d_rd;
            {d_e_reg_write, d_e_mem_read, d_e_mem_write, d_e_branch, d_e_branch_ne} <=
                {d_reg_write, d_mem_read, d_mem_write, d_branch, d_branch_ne};
            {d_e_jump, d_e_jalr, d_e_src_b_imm, d_e_src_a_pc} <=
                {d_jump, d_jalr, d_src_b_imm, d_src_a_pc};
        end
    end

    always_ff @(posedge clk) begin
        if (d_e_en) begin
            d_e_pc     <= f_d_pc;
            d_e_val_a  <= d_val_a;
            d_e_val_b  <= d_val_b;
            d_e_imm    <= d_imm;
            d_e_alu_op <= d_alu_op;
        end
    end

    hazard_unit u_hazard (
        .d_reg_a(d_rs1), .d_reg_b(d_rs2), .d_opcode(d_opcode),
        .ex_reg_a(d_e_rs1), .ex_reg_b(d_e_rs2), .ex_reg_d(d_e_rd), .ex_opcode(d_e_opcode),
        .mem_reg_write(e_m_reg_write), .mem_reg_addr(e_m_rd), .mem_opcode(e_m_opcode),
        .wb_reg_write(m_w_reg_write), .wb_reg_addr(m_w_rd), .wb_opcode(m_w_opcode),
        .branch(d_e_branch), .branch_taken(ex_branch_taken), .jump(d_e_jump),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .pc_en(pc_en), .f_d_en(f_d_en), .d_e_en(d_e_en),
        .no_op(no_op), .pc_src(pc_src), .flush(flush)
    );

    execute_unit u_execute (
        .pc(d_e_pc), .reg_a_val(d_e_val_a), .reg_b_val(d_e_val_b), .imm(d_e_imm),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_result(e_m_alu_result), .wb_result(m_w_result),
        .alu_op(d_e_alu_op), .src_a_pc(d_e_src_a_pc), .src_b_imm(d_e_src_b_imm),
        .branch(d_e_branch), .branch_ne(d_e_branch_ne), .jump(d_e_jump), .jalr(d_e_jalr),
        .alu_result(ex_alu_result), .store_data(ex_store_data),
        .branch_taken(ex_branch_taken), .target(ex_target)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_m_opcode <= op_nop;
            e_m_rd     <= '0;
            {e_m_reg_write, e_m_mem_read, e_m_mem_write} <= '0;
        end else begin
            e_m_opcode <= d_e_opcode;
            e_m_rd     <= d_e_rd;
            {e_m_reg_write, e_m_mem_read, e_m_mem_write} <=
                {d_e_reg_write, d_e_mem_read, d_e_mem_write};
        end
    end

    always_ff @(posedge clk) begin
        e_m_alu_result <= ex_alu_result;
        e_m_store_data <= ex_store_data;
    end

    data_memory u_dmem (
        .clk(clk), .rst_n(rst_n), .mem_read(e_m_mem_read), .mem_write(e_m_mem_write),
        .addr(e_m_alu_result), .wr_data(e_m_store_data), .rd_data(dmem_rd_data)
    );

    // writeback value picked before m/w
    assign m_result = e_m_mem_read ? dmem_rd_data : e_m_alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_w_opcode    <= op_nop;
            m_w_rd        <= '0;
            m_w_reg_write <= 1'b0;
        end else begin
            m_w_opcode    <= e_m_opcode;
            m_w_rd        <= e_m_rd;
            m_w_reg_write <= e_m_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        m_w_result <= m_result;
    end

    // writes to x0 are not retirements
    assign retire_valid = m_w_reg_write && (m_w_rd != '0);
    assign retire_rd    = m_w_rd;
    assign retire_data  = m_w_result;

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/1ns

module data_memory import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            mem_read,
    input  logic            mem_write,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wr_data,
    output logic [xlen-1:0] rd_data
);

    logic [xlen-1:0]                 ram [dmem_words];
    logic [$clog2(dmem_words)-1:0]   word_idx;

    // word index, byte offset dropped
    assign word_idx = addr[$clog2(dmem_words)+1:2];

    // no store lands while the core is held in reset
    always_ff @(posedge clk) begin
        if (rst_n && mem_write) begin
            ram[word_idx] <= wr_data;
        end
    end

    // zero unless a load is in the stage
    assign rd_data = mem_read ? ram[word_idx] : '0;

endmodule

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ns

module execute_unit import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] reg_a_val,
    input  logic [xlen-1:0] reg_b_val,
    input  logic [xlen-1:0] imm,
    input  forward_type     fwd_a,
    input  forward_type     fwd_b,
    input  logic [xlen-1:0] mem_result,
    input  logic [xlen-1:0] wb_result,
    input  alu_op_t         alu_op,
    input  logic            src_a_pc,
    input  logic            src_b_imm,
    input  logic            branch,
    input  logic            branch_ne,
    input  logic            jump,
    input  logic            jalr,
    output logic [xlen-1:0] alu_result,
    output logic [xlen-1:0] store_data,
    output logic            branch_taken,
    output logic [xlen-1:0] target
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_out;

    function automatic logic [xlen-1:0] pick(forward_type sel, logic [xlen-1:0] rf_val);
        case (sel)
            mem:       return mem_result;
            writeback: return wb_result;
            default:   return rf_val;
        endcase
    endfunction

    // forwarded register operands, also used by the compare and the store
    always_comb begin
        op_a = pick(fwd_a, reg_a_val);
        op_b = pick(fwd_b, reg_b_val);
    end

    assign src_a = src_a_pc ? pc : op_a;
    assign src_b = src_b_imm ? imm : op_b;

    always_comb begin
        case (alu_op)
            alu_sub:    alu_out = src_a - src_b;
            alu_and:    alu_out = src_a & src_b;
            alu_or:     alu_out = src_a | src_b;
            alu_xor:    alu_out = src_a ^ src_b;
            alu_slt:    alu_out = {{(xlen - 1){1'b0}}, $signed(src_a) < $signed(src_b)};
            alu_pass_b: alu_out = src_b;
            default:    alu_out = src_a + src_b;
        endcase
    end

    // jumps write the link address instead
    assign alu_result = jump ? pc + 32'd4 : alu_out;
    assign store_data = op_b;

    assign branch_taken = branch && (branch_ne ? (op_a != op_b) : (op_a == op_b));

    // jalr target has bit 0 cleared
    assign target = jalr ? ((op_a + imm) & ~32'd1) : pc + imm;

endmodule

// ==== logic/decode_unit.sv ====
`timescale 1ns/1ns

module decode_unit import rv_isa_pkg::*; (
    input  logic [xlen-1:0]       instr,
    output opcode_t               opcode,
    output logic [reg_addr_w-1:0] rs1,
    output logic [reg_addr_w-1:0] rs2,
    output logic [reg_addr_w-1:0] rd,
    output logic [xlen-1:0]       imm,
    output alu_op_t               alu_op,
    output logic                  reg_write,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  branch,
    output logic                  branch_ne,
    output logic                  jump,
    output logic                  jalr,
    output logic                  src_b_imm,
    output logic                  src_a_pc
);

    logic [2:0] funct3;
    logic       funct7_b5;

    assign rs1       = instr[19:15];
    assign rs2       = instr[24:20];
    assign rd        = instr[11:7];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    // anything outside the subset becomes a bubble
    always_comb begin
        case (instr[6:0])
            op_lui, op_auipc, op_jal, op_jalr, op_branch,
            op_load, op_store, op_imm, op_reg: opcode = opcode_t'(instr[6:0]);
            default: opcode = op_nop;
        endcase
    end

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            op_imm, op_load, op_jalr:
                imm = {{20{instr[31]}}, instr[31:20]};
            op_store:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            op_branch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            op_lui, op_auipc:
                imm = {instr[31:12], 12'b0};
            op_jal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    // loads, stores, auipc and branches all use the adder
    always_comb begin
        alu_op = alu_add;
        if (opcode == op_lui) begin
            alu_op = alu_pass_b;
        end else if (opcode inside {op_imm, op_reg}) begin
            case (funct3)
                // sub only exists in the register form
                3'b000:  alu_op = (opcode == op_reg && funct7_b5) ? alu_sub : alu_add;
                3'b010:  alu_op = alu_slt;
                3'b100:  alu_op = alu_xor;
                3'b110:  alu_op = alu_or;
                3'b111:  alu_op = alu_and;
                default: alu_op = alu_add;
            endcase
        end
    end

    assign reg_write = opcode inside {op_lui, op_auipc, op_jal, op_jalr,
                                      op_load, op_imm, op_reg};
    assign mem_read  = (opcode == op_load);
    assign mem_write = (opcode == op_store);
    assign branch    = (opcode == op_branch);
    // funct3 bit 0 separates bne from beq
    assign branch_ne = branch && funct3[0];
    assign jump      = opcode inside {op_jal, op_jalr};
    assign jalr      = (opcode == op_jalr);
    assign src_a_pc  = (opcode == op_auipc);
    assign src_b_imm = opcode inside {op_lui, op_auipc, op_load, op_store, op_imm, op_jalr};

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ns

module register_file import rv_isa_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] rd_addr_a,
    input  logic [reg_addr_w-1:0] rd_addr_b,
    output logic [xlen-1:0]       rd_data_a,
    output logic [xlen-1:0]       rd_data_b,
    input  logic                  wr_en,
    input  logic [reg_addr_w-1:0] wr_addr,
    input  logic [xlen-1:0]       wr_data
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:(1 << reg_addr_w) - 1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write shows through, decode sees the writeback value
    function automatic logic [xlen-1:0] read_port(logic [reg_addr_w-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && (wr_addr == addr)) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit import rv_isa_pkg::*, pipe_ctrl_pkg::*; (
    // decode stage sources
    input  logic [reg_addr_w-1:0] d_reg_a,
    input  logic [reg_addr_w-1:0] d_reg_b,
    input  opcode_t               d_opcode,
    // execute stage registers
    input  logic [reg_addr_w-1:0] ex_reg_a,
    input  logic [reg_addr_w-1:0] ex_reg_b,
    input  logic [reg_addr_w-1:0] ex_reg_d,
    input  opcode_t               ex_opcode,
    // memory stage destination
    input  logic                  mem_reg_write,
    input  logic [reg_addr_w-1:0] mem_reg_addr,
    input  opcode_t               mem_opcode,
    // writeback stage destination
    input  logic                  wb_reg_write,
    input  logic [reg_addr_w-1:0] wb_reg_addr,
    input  opcode_t               wb_opcode,
    // resolved control flow from execute
    input  logic                  branch,
    input  logic                  branch_taken,
    input  logic                  jump,
    output forward_type           fwd_a,
    output forward_type           fwd_b,
    output logic                  pc_en,
    output logic                  f_d_en,
    output logic                  d_e_en,
    output logic                  no_op,
    output logic                  pc_src,
    output logic                  flush
);

    logic d_a_used;
    logic d_b_used;
    logic ex_a_used;
    logic ex_b_used;
    logic mem_fwd_ok;
    logic wb_fwd_ok;
    logic load_use;
    logic redirect;
    logic stall;

    // lui, auipc and jal have no rs1, bubbles read nothing
    function automatic logic reads_a(opcode_t op);
        return !(op inside {op_lui, op_auipc, op_jal, op_nop});
    endfunction

    // only register ops, stores and branches read rs2
    function automatic logic reads_b(opcode_t op);
        return op inside {op_branch, op_store, op_reg};
    endfunction

    // a real write needs the enable, a nonzero rd and an opcode that has rd
    function automatic logic writes_rd(opcode_t op, logic we, logic [reg_addr_w-1:0] rd);
        return we && (rd != '0) && !(op inside {op_store, op_branch, op_nop});
    endfunction

    assign d_a_used  = reads_a(d_opcode);
    assign d_b_used  = reads_b(d_opcode);
    assign ex_a_used = reads_a(ex_opcode);
    assign ex_b_used = reads_b(ex_opcode);

    // load data is not ready in memory, so that stage only forwards alu results
    assign mem_fwd_ok = writes_rd(mem_opcode, mem_reg_write, mem_reg_addr)
                        && (mem_opcode != op_load);
    assign wb_fwd_ok  = writes_rd(wb_opcode, wb_reg_write, wb_reg_addr);

    // memory holds the younger result, so it wins over writeback
    always_comb begin
        fwd_a = none;
        fwd_b = none;
        if (ex_a_used && mem_fwd_ok && (ex_reg_a == mem_reg_addr)) begin
            fwd_a = mem;
        end else if (ex_a_used && wb_fwd_ok && (ex_reg_a == wb_reg_addr)) begin
            fwd_a = writeback;
        end
        if (ex_b_used && mem_fwd_ok && (ex_reg_b == mem_reg_addr)) begin
            fwd_b = mem;
        end else if (ex_b_used && wb_fwd_ok && (ex_reg_b == wb_reg_addr)) begin
            fwd_b = writeback;
        end
    end

    // load in execute feeding a source of the instruction in decode
    assign load_use = (ex_opcode == op_load) && (ex_reg_d != '0)
                      && ((d_a_used && (d_reg_a == ex_reg_d))
                          || (d_b_used && (d_reg_b == ex_reg_d)));

    // static not-taken, so any taken branch or jump is a redirect
    assign redirect = (branch && branch_taken) || jump;

    // a redirect kills the stalled decode instruction anyway
    assign stall = load_use && !redirect;

    assign pc_en  = !stall;
    assign f_d_en = !stall;
    assign d_e_en = !stall;
    assign no_op  = stall;
    assign pc_src = redirect;
    assign flush  = redirect;

endmodule

// ==== logic/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    // where an execute operand comes from
    // none means the value read from the register file in decode
    typedef enum logic [1:0] {
        none      = 2'b00,
        mem       = 2'b01,
        writeback = 2'b10
    } forward_type;

    // instruction rom depth in words
    localparam int imem_words = 64;
    // data ram depth in words
    localparam int dmem_words = 64;

endpackage

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // data word width
    localparam int xlen = 32;
    // register index width, 32 architectural registers
    localparam int reg_addr_w = 5;

    // major opcodes of the supported rv32i subset
    // op_nop is all zeros and marks a bubble in any stage
    typedef enum logic [6:0] {
        op_nop    = 7'b0000000,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_t;

    // alu operations, pass_b feeds the immediate straight through for lui
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

endpackage
